// File: mem_sram_bridge_cfg.svh
// -------------------------------------
// Memory bridge build configuration
// -------------------------------------

`ifndef MEM_SRAM_BRIDGE_CFG_SVH
`define MEM_SRAM_BRIDGE_CFG_SVH

// -------------------------------------
// Memory port widths
// -------------------------------------
`define MSB_ADDR_W 32                // Byte address
`define MSB_DATA_W 32                // One data word
`define MSB_STRB_W (`MSB_DATA_W / 8) // One strobe bit per byte

// -------------------------------------
// Request packet fields
// -------------------------------------
`define MSB_OFFSET_W 24 // Word offset from descriptor base
`define MSB_ID_W     8  // Tag returned with the response

// -------------------------------------
// Queueing
// -------------------------------------
// Shared by request FIFO and response FIFO
`define MSB_FIFO_DEPTH 16

// Programmable full level
// Leaves room for the ingress pipeline and
// the registered ready on the request side
`define MSB_PROG_THRESH 12

`endif

// File: mem_sram_pkg.sv
// -------------------------------------
// Memory bridge types and mapping
// -------------------------------------

`include "mem_sram_bridge_cfg.svh"

package mem_sram_pkg;

  // Command set from the overlay
  typedef enum logic [2:0] {
    CMD_MEM_READ     = 3'd0,
    CMD_MEM_WRITE    = 3'd1,
    CMD_STREAM_READ  = 3'd2,
    CMD_STREAM_WRITE = 3'd3,
    CMD_CACHE_FLUSH  = 3'd4  // Treated as read class
  } mem_cmd_e;

  // -------------------------------------
  // Packet types
  // -------------------------------------
  typedef struct packed {
    logic [`MSB_ID_W-1:0]     id;
    mem_cmd_e                 cmd;
    logic [`MSB_OFFSET_W-1:0] offset; // Word index, not bytes
    logic [`MSB_DATA_W-1:0]   wdata;
    logic [`MSB_STRB_W-1:0]   strb;
  } mem_req_t;

  // Request FIFO entry
  typedef struct packed {
    logic [`MSB_ID_W-1:0]   id;
    mem_cmd_e               cmd;
    logic [`MSB_ADDR_W-1:0] addr;
    logic [`MSB_DATA_W-1:0] wdata;
    logic [`MSB_STRB_W-1:0] strb;
  } mem_op_t;

  // Response FIFO entry
  typedef struct packed {
    logic [`MSB_ID_W-1:0]   id;
    mem_cmd_e               cmd;
    logic [`MSB_ADDR_W-1:0] addr;
    logic [`MSB_DATA_W-1:0] wdata; // Echoed back on writes
    logic                   we;
  } mem_meta_t;

  typedef struct packed {
    logic [`MSB_ID_W-1:0]   id;
    mem_cmd_e               cmd;
    logic [`MSB_ADDR_W-1:0] addr;
    logic [`MSB_DATA_W-1:0] data;
  } mem_rsp_t;

  // -------------------------------------
  // Mapping functions
  // -------------------------------------
  // Base plus offset scaled to bytes
  function automatic mem_op_t map_request(mem_req_t req, logic [`MSB_ADDR_W-1:0] base);
    mem_op_t op;
    op.id    = req.id;
    op.cmd   = req.cmd;
    op.addr  = base + (`MSB_ADDR_W'(req.offset) * `MSB_ADDR_W'(`MSB_STRB_W));
    op.wdata = req.wdata;
    op.strb  = req.strb;
    return op;
  endfunction

  // Writes echo their data, reads take memory data
  function automatic mem_rsp_t map_response(mem_meta_t meta, logic [`MSB_DATA_W-1:0] rdata);
    mem_rsp_t rsp;
    rsp.id   = meta.id;
    rsp.cmd  = meta.cmd;
    rsp.addr = meta.addr;
    rsp.data = meta.we ? meta.wdata : rdata;
    return rsp;
  endfunction

endpackage

// File: sync_fifo.sv
// -------------------------------------
// Synchronous FWFT FIFO
// -------------------------------------

`include "mem_sram_bridge_cfg.svh"

module sync_fifo #(
  parameter int DEPTH       = `MSB_FIFO_DEPTH,
  parameter int WIDTH       = 32,
  parameter int PROG_THRESH = `MSB_PROG_THRESH
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             valid_o,
  output logic             empty_o,
  output logic             full_o,
  output logic             prog_full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // -------------------------------------
  // Storage and pointers
  // -------------------------------------
  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count; // Occupancy
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en_i & ~full_o;  // Push dropped when full
  assign do_rd = rd_en_i & ~empty_o; // Pop ignored when empty

  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  // -------------------------------------
  // Status and head
  // -------------------------------------
  // Head visible without a read
  assign dout_o      = mem[rd_ptr];
  assign empty_o     = (count == '0);
  assign valid_o     = ~empty_o;
  assign full_o      = (count == CNT_W'(DEPTH));
  assign prog_full_o = (count >= CNT_W'(PROG_THRESH));

endmodule

// File: request_ingress.sv
// -------------------------------------
// Descriptor and request input stages
// -------------------------------------

`include "mem_sram_bridge_cfg.svh"

module request_ingress (
  input  logic                     ap_clk,
  input  logic                     areset_control,
  input  logic                     descriptor_valid_i,
  input  logic [`MSB_ADDR_W-1:0]   descriptor_base_i,
  input  logic                     req_valid_i,
  input  logic                     req_ready_i,
  input  mem_sram_pkg::mem_req_t   req_i,
  output logic                     armed_o,
  output logic                     op_valid_o,
  output mem_sram_pkg::mem_op_t    op_o,
  output logic                     busy_o
);

  logic                   armed_q;
  logic [`MSB_ADDR_W-1:0] base_q;   // Descriptor base address
  logic                   s1_valid;
  mem_sram_pkg::mem_req_t s1_req;   // Raw request
  logic                   s2_valid;
  mem_sram_pkg::mem_op_t  s2_op;    // Mapped request

  // -------------------------------------
  // Descriptor
  // -------------------------------------
  // Armed on the first descriptor, held until reset
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      armed_q <= 1'b0;
    end else if (descriptor_valid_i) begin
      armed_q <= 1'b1;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (descriptor_valid_i) begin
      base_q <= descriptor_base_i; // Later descriptors replace the base
    end
  end

  // -------------------------------------
  // Two stage input pipeline
  // -------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid_i & req_ready_i; // Handshake only
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    s1_req <= req_i;
    s2_op  <= mem_sram_pkg::map_request(s1_req, base_q); // Address mapping
  end

  assign armed_o    = armed_q;
  assign op_valid_o = s2_valid; // FIFO push
  assign op_o       = s2_op;
  assign busy_o     = s1_valid | s2_valid; // Work still in the pipe

endmodule

// File: command_issue.sv
// -------------------------------------
// Memory command issue stage
// -------------------------------------

`include "mem_sram_bridge_cfg.svh"

module command_issue (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  input  logic                   head_valid_i,
  input  mem_sram_pkg::mem_op_t  head_i,
  input  logic                   armed_i,
  input  logic                   consumer_ready_i,
  input  logic                   rsp_fifo_prog_full_i,
  output logic                   head_pop_o,
  output logic                   mem_req_o,
  output logic [`MSB_ADDR_W-1:0] mem_addr_o,
  output logic                   mem_we_o,
  output logic [`MSB_DATA_W-1:0] mem_wdata_o,
  output logic [`MSB_STRB_W-1:0] mem_strb_o,
  input  logic                   mem_gnt_i,
  output logic                   issued_o,
  output mem_sram_pkg::mem_meta_t meta_o
);

  logic consumer_ready_q;
  logic issue_gate;
  logic cmd_write; // Write class head
  logic grant;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      consumer_ready_q <= 1'b0; // Hold off issue until consumer seen
    end else begin
      consumer_ready_q <= consumer_ready_i;
    end
  end

  // -------------------------------------
  // Gate and decode
  // -------------------------------------
  assign issue_gate = armed_i & consumer_ready_q & ~rsp_fifo_prog_full_i;

  always_comb begin
    case (head_i.cmd)
      mem_sram_pkg::CMD_MEM_WRITE,
      mem_sram_pkg::CMD_STREAM_WRITE: cmd_write = 1'b1;
      default:                        cmd_write = 1'b0; // Reads and flush
    endcase
  end

  // Request held with stable fields until grant
  assign mem_req_o   = head_valid_i & issue_gate;
  assign mem_addr_o  = head_i.addr;
  assign mem_we_o    = cmd_write;
  assign mem_wdata_o = head_i.wdata;
  assign mem_strb_o  = head_i.strb & {`MSB_STRB_W{cmd_write}}; // Zero on reads

  // -------------------------------------
  // Grant
  // -------------------------------------
  assign grant      = mem_req_o & mem_gnt_i; // One op per grant
  assign head_pop_o = grant;
  assign issued_o   = grant;

  assign meta_o.id    = head_i.id;
  assign meta_o.cmd   = head_i.cmd;
  assign meta_o.addr  = head_i.addr;
  assign meta_o.wdata = head_i.wdata;
  assign meta_o.we    = cmd_write;

endmodule

// File: response_merge.sv
// -------------------------------------
// Response pairing and output register
// -------------------------------------

`include "mem_sram_bridge_cfg.svh"

module response_merge (
  input  logic                    ap_clk,
  input  logic                    areset_control,
  input  logic                    issued_i,
  input  mem_sram_pkg::mem_meta_t meta_i,
  input  logic                    mem_rsp_valid_i,
  input  logic [`MSB_DATA_W-1:0]  mem_rdata_i,
  output logic                    prog_full_o,
  output logic                    empty_o,
  output logic                    rsp_valid_o,
  output mem_sram_pkg::mem_rsp_t  rsp_o
);

  mem_sram_pkg::mem_meta_t meta_head; // Oldest issued op
  logic                    meta_valid;
  logic                    meta_pop;

  // -------------------------------------
  // Metadata FIFO
  // -------------------------------------
  // Responses come back in issue order, so the head always matches
  assign meta_pop = mem_rsp_valid_i & meta_valid;

  sync_fifo #(
    .DEPTH      (`MSB_FIFO_DEPTH),
    .WIDTH      ($bits(mem_sram_pkg::mem_meta_t)),
    .PROG_THRESH(`MSB_PROG_THRESH)
  ) i_meta_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en_i       (issued_i),   // Push on grant
    .din_i         (meta_i),
    .rd_en_i       (meta_pop),   // Pop on memory response
    .dout_o        (meta_head),
    .valid_o       (meta_valid),
    .empty_o       (empty_o),
    .full_o        (),
    .prog_full_o   (prog_full_o) // Throttles issue
  );

  // -------------------------------------
  // Output register
  // -------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= meta_pop; // One cycle after memory response
    end
  end

  always_ff @(posedge ap_clk) begin
    if (meta_pop) begin
      rsp_o <= mem_sram_pkg::map_response(meta_head, mem_rdata_i);
    end
  end

endmodule

// File: mem_sram_bridge.sv
// -------------------------------------
// Memory request bridge top
// -------------------------------------

`include "mem_sram_bridge_cfg.svh"

module mem_sram_bridge (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  // Descriptor
  input  logic                   descriptor_valid_i,
  input  logic [`MSB_ADDR_W-1:0] descriptor_base_i,
  // Request input
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  mem_sram_pkg::mem_req_t req_i,
  input  logic                   consumer_ready_i,
  // Memory port
  output logic                   mem_req_o,
  output logic [`MSB_ADDR_W-1:0] mem_addr_o,
  output logic                   mem_we_o,
  output logic [`MSB_DATA_W-1:0] mem_wdata_o,
  output logic [`MSB_STRB_W-1:0] mem_strb_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rsp_valid_i,
  input  logic [`MSB_DATA_W-1:0] mem_rdata_i,
  // Response output, no ready
  output logic                   rsp_valid_o,
  output mem_sram_pkg::mem_rsp_t rsp_o,
  output logic                   done_o
);

  logic                    armed;
  logic                    busy;       // Ingress stages occupied
  logic                    op_valid;
  mem_sram_pkg::mem_op_t   op;
  logic                    head_valid;
  mem_sram_pkg::mem_op_t   head;
  logic                    head_pop;
  logic                    req_empty;
  logic                    req_prog_full;
  logic                    issued;
  mem_sram_pkg::mem_meta_t meta;
  logic                    rsp_prog_full;
  logic                    rsp_empty;
  logic                    idle_q;     // First done stage

  // -------------------------------------
  // Request path
  // -------------------------------------
  request_ingress i_ingress (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .descriptor_valid_i(descriptor_valid_i),
    .descriptor_base_i (descriptor_base_i),
    .req_valid_i       (req_valid_i),
    .req_ready_i       (req_ready_o),
    .req_i             (req_i),
    .armed_o           (armed),
    .op_valid_o        (op_valid),
    .op_o              (op),
    .busy_o            (busy)
  );

  sync_fifo #(
    .DEPTH      (`MSB_FIFO_DEPTH),
    .WIDTH      ($bits(mem_sram_pkg::mem_op_t)),
    .PROG_THRESH(`MSB_PROG_THRESH)
  ) i_req_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en_i       (op_valid),
    .din_i         (op),
    .rd_en_i       (head_pop),
    .dout_o        (head),      // FWFT head to issue
    .valid_o       (head_valid),
    .empty_o       (req_empty),
    .full_o        (),
    .prog_full_o   (req_prog_full)
  );

  command_issue i_issue (
    .ap_clk              (ap_clk),
    .areset_control      (areset_control),
    .head_valid_i        (head_valid),
    .head_i              (head),
    .armed_i             (armed),
    .consumer_ready_i    (consumer_ready_i),
    .rsp_fifo_prog_full_i(rsp_prog_full),
    .head_pop_o          (head_pop),
    .mem_req_o           (mem_req_o),
    .mem_addr_o          (mem_addr_o),
    .mem_we_o            (mem_we_o),
    .mem_wdata_o         (mem_wdata_o),
    .mem_strb_o          (mem_strb_o),
    .mem_gnt_i           (mem_gnt_i),
    .issued_o            (issued),
    .meta_o              (meta)
  );

  // -------------------------------------
  // Response path
  // -------------------------------------
  response_merge i_merge (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .issued_i       (issued),
    .meta_i         (meta),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rdata_i    (mem_rdata_i),
    .prog_full_o    (rsp_prog_full),
    .empty_o        (rsp_empty),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o)
  );

  // -------------------------------------
  // Ready and done
  // -------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_ready_o <= 1'b0;
      idle_q      <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      req_ready_o <= ~req_prog_full;                    // Room left in request FIFO
      idle_q      <= req_empty & rsp_empty & ~busy;     // Nothing queued or in flight
      done_o      <= idle_q;
    end
  end

endmodule

// File: tb_mem_responder.sv
// ----------------------------------------
// Memory model for the bridge testbench
// ----------------------------------------

`include "mem_sram_bridge_cfg.svh"

module tb_mem_responder (
  input  logic                   ap_clk,
  input  logic                   stall_i,     // Holds off all grants
  input  logic                   mem_req_i,
  input  logic [`MSB_ADDR_W-1:0] mem_addr_i,
  input  logic                   mem_we_i,
  input  logic [`MSB_DATA_W-1:0] mem_wdata_i,
  input  logic [`MSB_STRB_W-1:0] mem_strb_i,
  output logic                   mem_gnt_o,
  output logic                   mem_rsp_valid_o,
  output logic [`MSB_DATA_W-1:0] mem_rdata_o
);

  logic [`MSB_DATA_W-1:0] words [256];   // Indexed by addr[9:2]
  logic [`MSB_DATA_W-1:0] data_q [$];    // Pending responses, in order
  int                     due_q [$];     // Cycle each response may leave
  int                     cyc;
  int                     last_due;
  logic [7:0]             idx;

  initial begin
    for (int i = 0; i < 256; i++) begin
      words[i] = 32'hC0DE_0000 | 32'(i); // Fill follows the word index
    end
    mem_gnt_o       = 1'b0;
    mem_rsp_valid_o = 1'b0;
    mem_rdata_o     = '0;
    cyc             = 0;
    last_due        = 0;
  end

  // ----------------------------------------
  // Accept, sampled at the falling edge
  // ----------------------------------------
  always @(negedge ap_clk) begin
    if (mem_req_i && mem_gnt_o) begin
      idx = mem_addr_i[9:2];
      if (mem_we_i) begin
        for (int b = 0; b < `MSB_STRB_W; b++) begin
          if (mem_strb_i[b]) words[idx][8*b +: 8] = mem_wdata_i[8*b +: 8];
        end
      end
      data_q.push_back(words[idx]);
      last_due = (last_due > cyc + 1) ? last_due : cyc + 1 + int'($urandom % 4);
      due_q.push_back(last_due); // Never earlier than the one before
    end
  end

  // Drive a little after the rising edge
  always @(posedge ap_clk) begin
    cyc = cyc + 1;
    #1;
    mem_gnt_o       = !stall_i && ($urandom % 4 != 0);
    mem_rsp_valid_o = 1'b0;
    if (due_q.size() != 0 && due_q[0] <= cyc) begin
      void'(due_q.pop_front());
      mem_rdata_o     = data_q.pop_front();
      mem_rsp_valid_o = 1'b1; // One response per cycle at most
    end
  end

endmodule

// File: tb_mem_sram_bridge.sv
// ----------------------------------------
// Memory bridge testbench
// ----------------------------------------

`include "mem_sram_bridge_cfg.svh"

module tb_mem_sram_bridge;

  localparam int TIMEOUT = 3000; // Cycles per wait

  logic                    ap_clk;
  logic                    areset_control;
  logic                    descriptor_valid_i;
  logic [`MSB_ADDR_W-1:0]  descriptor_base_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  mem_sram_pkg::mem_req_t  req_i;
  logic                    consumer_ready_i;
  logic                    mem_req_o;
  logic [`MSB_ADDR_W-1:0]  mem_addr_o;
  logic                    mem_we_o;
  logic [`MSB_DATA_W-1:0]  mem_wdata_o;
  logic [`MSB_STRB_W-1:0]  mem_strb_o;
  logic                    mem_gnt_i;
  logic                    mem_rsp_valid_i;
  logic [`MSB_DATA_W-1:0]  mem_rdata_i;
  logic                    rsp_valid_o;
  mem_sram_pkg::mem_rsp_t  rsp_o;
  logic                    done_o;
  logic                    stall;
  logic                    toggle_consumer;
  logic                    model_on;

  // Reference model state
  mem_sram_pkg::mem_rsp_t  exp_rsp_q [$];
  logic                    exp_we_q [$];
  logic [`MSB_STRB_W-1:0]  exp_strb_q [$];
  logic [`MSB_ADDR_W-1:0]  exp_addr_q [$];
  logic [`MSB_DATA_W-1:0]  exp_wdata_q [$]; // Writes only
  logic [`MSB_DATA_W-1:0]  model_mem [256];
  int                      errors;
  int                      checks;
  int                      timeouts;
  int                      next_id;

  mem_sram_bridge i_dut (.*);

  tb_mem_responder i_mem (
    .ap_clk         (ap_clk),
    .stall_i        (stall),
    .mem_req_i      (mem_req_o),
    .mem_addr_i     (mem_addr_o),
    .mem_we_i       (mem_we_o),
    .mem_wdata_i    (mem_wdata_o),
    .mem_strb_i     (mem_strb_o),
    .mem_gnt_o      (mem_gnt_i),
    .mem_rsp_valid_o(mem_rsp_valid_i),
    .mem_rdata_o    (mem_rdata_i)
  );

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_rsp(string name, mem_sram_pkg::mem_rsp_t exp,
                           mem_sram_pkg::mem_rsp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_strb(string name, logic [`MSB_STRB_W-1:0] exp,
                            logic [`MSB_STRB_W-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, logic [`MSB_ADDR_W-1:0] exp,
                            logic [`MSB_ADDR_W-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(string name, logic [`MSB_DATA_W-1:0] exp,
                            logic [`MSB_DATA_W-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic step();
    @(posedge ap_clk);
    #1;
  endtask

  task automatic note_timeout(string what);
    timeouts++;
    $display("Timed out waiting for %s", what);
  endtask

  // ----------------------------------------
  // Model and stimulus
  // ----------------------------------------
  // Expected response from the mapping rule and the model memory
  task automatic expect_req(mem_sram_pkg::mem_req_t r);
    mem_sram_pkg::mem_rsp_t e;
    logic                   wr;
    logic [7:0]             idx;
    wr     = (r.cmd == mem_sram_pkg::CMD_MEM_WRITE) ||
             (r.cmd == mem_sram_pkg::CMD_STREAM_WRITE);
    e.id   = r.id;
    e.cmd  = r.cmd;
    e.addr = descriptor_base_i + {8'h00, r.offset} * 32'(`MSB_STRB_W);
    idx    = e.addr[9:2];
    if (wr) begin
      for (int b = 0; b < `MSB_STRB_W; b++) begin
        if (r.strb[b]) model_mem[idx][8*b +: 8] = r.wdata[8*b +: 8];
      end
      exp_wdata_q.push_back(r.wdata);
    end
    e.data = wr ? r.wdata : model_mem[idx];  // Writes echo their data
    exp_rsp_q.push_back(e);
    exp_we_q.push_back(wr);
    exp_strb_q.push_back(wr ? r.strb : '0);  // Reads see no strobe
    exp_addr_q.push_back(e.addr);
  endtask

  task automatic send_req(logic model);
    mem_sram_pkg::mem_req_t r;
    int                     t;
    r.id     = 8'(next_id);
    r.cmd    = mem_sram_pkg::mem_cmd_e'(3'($urandom % 5));
    r.offset = `MSB_OFFSET_W'($urandom % 64);
    r.wdata  = $urandom;
    r.strb   = `MSB_STRB_W'($urandom);
    next_id++;
    req_i       = r;
    req_valid_i = 1'b1;
    t = 0;
    while (!req_ready_o && t < TIMEOUT) begin
      step();
      t++;
    end
    if (!req_ready_o) begin
      note_timeout("req_ready_o");
    end else begin
      step(); // Transfer on this edge
      if (model) expect_req(r);
    end
    req_valid_i = 1'b0;
  endtask

  task automatic send_batch(int n);
    for (int i = 0; i < n; i++) begin
      send_req(1'b1);
      if ($urandom % 3 == 0) step(); // Occasional gap
    end
  endtask

  task automatic apply_reset();
    areset_control = 1'b1;
    repeat (10) step();
    check_bit("reset req_ready_o", 1'b0, req_ready_o);
    check_bit("reset mem_req_o", 1'b0, mem_req_o);
    check_bit("reset rsp_valid_o", 1'b0, rsp_valid_o);
    check_bit("reset done_o", 1'b0, done_o);
    areset_control = 1'b0;
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    while (!done_o && t < TIMEOUT) begin
      step();
      t++;
    end
    if (!done_o) note_timeout("done_o");
  endtask

  // Stall memory until the request side backs up
  task automatic wait_ready_low();
    int t;
    t = 0;
    while (req_ready_o && t < TIMEOUT) begin
      step();
      t++;
    end
    check_bit("req_ready_o under stall", 1'b0, req_ready_o);
    repeat (5) step();
    stall = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_rsp_q.size() != 0 && t < TIMEOUT) begin
      step();
      t++;
    end
    if (exp_rsp_q.size() != 0) note_timeout("outstanding responses");
  endtask

  // ----------------------------------------
  // Monitor, sampled at the falling edge
  // ----------------------------------------
  always @(negedge ap_clk) begin
    if (model_on && !areset_control) begin
      if (mem_req_o && mem_gnt_i) begin
        if (exp_we_q.size() == 0) begin
          errors++;
          $display("Memory grant taken with no request outstanding");
        end else begin
          if (exp_we_q[0]) begin
            check_data("mem_wdata_o", exp_wdata_q.pop_front(), mem_wdata_o);
          end
          check_bit("mem_we_o", exp_we_q.pop_front(), mem_we_o);
          check_strb("mem_strb_o", exp_strb_q.pop_front(), mem_strb_o);
          check_addr("mem_addr_o", exp_addr_q.pop_front(), mem_addr_o);
        end
      end
      if (rsp_valid_o) begin
        if (exp_rsp_q.size() == 0) begin
          errors++;
          $display("Response arrived with none expected");
        end else begin
          check_rsp("response", exp_rsp_q.pop_front(), rsp_o);
        end
      end
    end
  end

  always @(posedge ap_clk) begin
    #1;
    consumer_ready_i = toggle_consumer ? ($urandom % 4 != 0) : 1'b1;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    void'($urandom(1));
    areset_control     = 1'b1;
    descriptor_valid_i = 1'b0;
    descriptor_base_i  = 32'h0000_1000;
    req_valid_i        = 1'b0;
    req_i              = '0;
    consumer_ready_i   = 1'b1;
    stall              = 1'b0;
    toggle_consumer    = 1'b0;
    model_on           = 1'b0;
    errors             = 0;
    checks             = 0;
    timeouts           = 0;
    next_id            = 0;
    for (int i = 0; i < 256; i++) model_mem[i] = 32'hC0DE_0000 | 32'(i);

    // Unarmed unit stays idle and never issues
    apply_reset();
    wait_done();
    send_req(1'b0);
    send_req(1'b0);
    repeat (30) begin
      step();
      check_bit("mem_req_o unarmed", 1'b0, mem_req_o);
    end

    apply_reset();
    model_on = 1'b1;
    descriptor_valid_i = 1'b1;
    step();
    descriptor_valid_i = 1'b0;
    send_batch(40);                        // Mapping, writes and reads
    wait_drain();

    toggle_consumer = 1'b1;
    stall = 1'b1;
    fork
      send_batch(40);
      wait_ready_low();
    join
    send_batch(60);
    wait_drain();
    toggle_consumer = 1'b0;

    wait_done();
    repeat (20) begin
      step();
      check_bit("done_o held", 1'b1, done_o);
    end

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: mem_sram_bridge.f
+incdir+.
mem_sram_pkg.sv
sync_fifo.sv
request_ingress.sv
command_issue.sv
response_merge.sv
mem_sram_bridge.sv
tb_mem_responder.sv
tb_mem_sram_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mem_sram_bridge.f \
  --top-module tb_mem_sram_bridge -o tb_sim || exit 1

OUT=$(./obj_dir/tb_sim)
echo "$OUT"
echo "$OUT" | grep -qx "TEST OK" && exit 0 || exit 1
